//--- source/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// ==================================================
// data path sizes.
// ==================================================

// bus and register width.
`define DATA_WIDTH 32

// words in the data RAM, higher word indices are bus errors.
`define RAM_WORDS 256

// destination register index width.
`define REG_SEL_WIDTH 3

`endif

//--- source/cpu_pkg.sv
`include "mem_params.svh"

package cpu_pkg;

	// ==================================================
	// pipeline side types.
	// ==================================================

	// size of a load or store, encoding 3 acts as a word.
	typedef enum logic [1:0] {
		width_byte = 2'd0,
		width_half = 2'd1,
		width_word = 2'd2
	} mem_width_t;

	// destination register index.
	typedef logic [`REG_SEL_WIDTH-1:0] reg_sel_t;

endpackage

//--- source/bus_pkg.sv
package bus_pkg;

	// ==================================================
	// data bus side types.
	// ==================================================

	// kind of response that comes with an ack.
	typedef enum logic {
		resp_okay  = 1'b0,
		resp_error = 1'b1
	} bus_resp_t;

	// RAM controller states.
	typedef enum logic [1:0] {
		ram_idle = 2'd0,
		ram_wait = 2'd1,
		ram_ack  = 2'd2
	} ram_state_t;

endpackage

//--- source/data_bus_if.sv
`timescale 1ns/1ps
`include "mem_params.svh"

interface data_bus_if (
	input logic clk,
	input logic rst
);

	logic [`DATA_WIDTH-1:0] addr;
	logic [`DATA_WIDTH/8-1:0] bytesel;
	logic wr_en;
	logic [`DATA_WIDTH-1:0] wr_val;
	logic access;
	logic [`DATA_WIDTH-1:0] rd_data;
	logic ack;
	bus_pkg::bus_resp_t resp;

	modport master (
		output addr, bytesel, wr_en, wr_val, access,
		input rd_data, ack, resp
	);

	modport slave (
		input addr, bytesel, wr_en, wr_val, access,
		output rd_data, ack, resp
	);

	// a slave only acks a request that the master still holds.
	ack_needs_access: assert property (@(posedge clk) disable iff (rst) ack |-> access);

endinterface

//--- source/mem_stage.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_stage (
	input logic clk,
	input logic rst,
	// pipeline request.
	input logic load,
	input logic store,
	input logic [`DATA_WIDTH-1:0] addr,
	input logic [`DATA_WIDTH-1:0] mdr,
	input logic mem_wr_en,
	input cpu_pkg::mem_width_t width,
	// writeback of non-memory instructions.
	input logic [`DATA_WIDTH-1:0] wr_val,
	input logic update_rd,
	input cpu_pkg::reg_sel_t rd_sel,
	output logic [`DATA_WIDTH-1:0] reg_wr_val,
	output logic update_rd_out,
	output cpu_pkg::reg_sel_t rd_sel_out,
	output logic complete,
	output logic fault,
	// debug controller.
	input logic dbg_en,
	input logic dbg_access,
	input logic dbg_wr_en,
	input logic [`DATA_WIDTH-1:0] dbg_addr,
	input cpu_pkg::mem_width_t dbg_width,
	input logic [`DATA_WIDTH-1:0] dbg_wr_val,
	output logic [`DATA_WIDTH-1:0] dbg_rd_val,
	output logic dbg_compl,
	data_bus_if.master bus
);

	localparam int BYTES = `DATA_WIDTH / 8;
	localparam logic [BYTES-1:0] SEL_BYTE = BYTES'(1);
	localparam logic [BYTES-1:0] SEL_HALF = BYTES'(3);
	localparam logic [BYTES-1:0] SEL_WORD = '1;

	logic [`DATA_WIDTH-1:0] req_addr;
	logic [`DATA_WIDTH-1:0] req_data;
	cpu_pkg::mem_width_t req_width;
	logic [1:0] byte_off;
	logic half_off;
	logic [`DATA_WIDTH-1:0] rd_shifted;
	logic [`DATA_WIDTH-1:0] rd_aligned;

	logic [`DATA_WIDTH-1:0] wr_val_bypass;
	logic update_rd_bypass;
	cpu_pkg::reg_sel_t rd_sel_bypass;
	cpu_pkg::reg_sel_t load_rd;
	logic load_pending;

	// ==================================================
	// request select.
	// ==================================================

	assign req_addr = dbg_en ? dbg_addr : addr;
	assign req_data = dbg_en ? dbg_wr_val : mdr;
	assign req_width = dbg_en ? dbg_width : width;

	assign bus.addr = {req_addr[`DATA_WIDTH-1:2], 2'b00};
	assign bus.wr_en = dbg_en ? dbg_wr_en : mem_wr_en;
	assign bus.access = dbg_en ? dbg_access : (load | store);

	assign byte_off = req_addr[1:0];
	assign half_off = req_addr[1];

	// ==================================================
	// lane steering and read alignment.
	// ==================================================

	always_comb begin
		case (req_width)
		cpu_pkg::width_byte: begin
			bus.bytesel = SEL_BYTE << byte_off;
			bus.wr_val = req_data << {byte_off, 3'b000};
			rd_shifted = bus.rd_data >> {byte_off, 3'b000};
			rd_aligned = {{(`DATA_WIDTH-8){1'b0}}, rd_shifted[7:0]};
		end
		cpu_pkg::width_half: begin
			bus.bytesel = SEL_HALF << {half_off, 1'b0};
			bus.wr_val = req_data << {half_off, 4'b0000};
			rd_shifted = bus.rd_data >> {half_off, 4'b0000};
			rd_aligned = {{(`DATA_WIDTH-16){1'b0}}, rd_shifted[15:0]};
		end
		default: begin
			// word, and the unused encoding.
			bus.bytesel = SEL_WORD;
			bus.wr_val = req_data;
			rd_shifted = bus.rd_data;
			rd_aligned = rd_shifted;
		end
		endcase
	end

	// ==================================================
	// writeback.
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_val_bypass <= '0;
			update_rd_bypass <= 1'b0;
			rd_sel_bypass <= '0;
			load_rd <= '0;
			load_pending <= 1'b0;
		end else begin
			wr_val_bypass <= wr_val;
			update_rd_bypass <= update_rd;
			rd_sel_bypass <= rd_sel;
			if (load)
				load_rd <= rd_sel;
			// remembers whether the access in flight is a load.
			if (load || store)
				load_pending <= load;
		end
	end

	assign complete = bus.ack;
	assign fault = complete && (bus.resp == bus_pkg::resp_error);

	assign reg_wr_val = complete ? rd_aligned : wr_val_bypass;
	assign rd_sel_out = complete ? load_rd : rd_sel_bypass;
	assign update_rd_out = complete ? (load_pending && !dbg_en && !fault) : update_rd_bypass;

	assign dbg_rd_val = rd_aligned;
	assign dbg_compl = complete;

	// a request stays up and unchanged until the RAM acks it.
	request_held: assert property (@(posedge clk) disable iff (rst)
		bus.access && !bus.ack |=> bus.access && $stable(bus.addr) && $stable(bus.bytesel)
			&& $stable(bus.wr_en) && $stable(bus.wr_val));

endmodule

//--- source/data_ram.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module data_ram (
	input logic clk,
	input logic rst,
	data_bus_if.slave bus
);

	localparam int BYTES = `DATA_WIDTH / 8;
	localparam int IDX_WIDTH = $clog2(`RAM_WORDS);

	logic [`DATA_WIDTH-1:0] mem [`RAM_WORDS];

	bus_pkg::ram_state_t state;
	logic [`DATA_WIDTH-3:0] word_idx;
	logic [IDX_WIDTH-1:0] ram_idx;
	logic in_range;
	logic start;
	logic [`DATA_WIDTH-1:0] rd_q;
	bus_pkg::bus_resp_t resp_q;

	assign word_idx = bus.addr[`DATA_WIDTH-1:2];
	assign ram_idx = word_idx[IDX_WIDTH-1:0];
	assign in_range = word_idx < `RAM_WORDS;
	assign start = (state == bus_pkg::ram_idle) && bus.access;

	// ==================================================
	// controller.
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= bus_pkg::ram_idle;
		end else begin
			case (state)
			bus_pkg::ram_idle: begin
				if (bus.access)
					state <= bus_pkg::ram_wait;
			end
			bus_pkg::ram_wait: state <= bus_pkg::ram_ack;
			// one idle cycle follows each ack.
			default: state <= bus_pkg::ram_idle;
			endcase
		end
	end

	// ==================================================
	// storage.
	// ==================================================

	always_ff @(posedge clk) begin
		if (start && !rst) begin
			if (in_range) begin
				rd_q <= mem[ram_idx];
				resp_q <= bus_pkg::resp_okay;
			end else begin
				rd_q <= '0;
				resp_q <= bus_pkg::resp_error;
			end
			if (bus.wr_en && in_range) begin
				for (int i = 0; i < BYTES; i++) begin
					if (bus.bytesel[i])
						mem[ram_idx][i*8 +: 8] <= bus.wr_val[i*8 +: 8];
				end
			end
		end
	end

	assign bus.ack = (state == bus_pkg::ram_ack);
	assign bus.rd_data = rd_q;
	assign bus.resp = resp_q;

	// a request that starts has a known address and write control.
	request_known: assert property (@(posedge clk) disable iff (rst)
		start |-> !$isunknown({bus.addr, bus.wr_en, bus.bytesel}));

endmodule

//--- source/mem_subsys_top.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_subsys_top (
	input logic clk,
	input logic rst,
	input logic load,
	input logic store,
	input logic [`DATA_WIDTH-1:0] addr,
	input logic [`DATA_WIDTH-1:0] mdr,
	input logic mem_wr_en,
	input cpu_pkg::mem_width_t width,
	input logic [`DATA_WIDTH-1:0] wr_val,
	input logic update_rd,
	input cpu_pkg::reg_sel_t rd_sel,
	output logic [`DATA_WIDTH-1:0] reg_wr_val,
	output logic update_rd_out,
	output cpu_pkg::reg_sel_t rd_sel_out,
	output logic complete,
	output logic fault,
	input logic dbg_en,
	input logic dbg_access,
	input logic dbg_wr_en,
	input logic [`DATA_WIDTH-1:0] dbg_addr,
	input cpu_pkg::mem_width_t dbg_width,
	input logic [`DATA_WIDTH-1:0] dbg_wr_val,
	output logic [`DATA_WIDTH-1:0] dbg_rd_val,
	output logic dbg_compl
);

	data_bus_if bus (
		.clk(clk),
		.rst(rst)
	);

	mem_stage u_mem_stage (
		.clk(clk),
		.rst(rst),
		.load(load),
		.store(store),
		.addr(addr),
		.mdr(mdr),
		.mem_wr_en(mem_wr_en),
		.width(width),
		.wr_val(wr_val),
		.update_rd(update_rd),
		.rd_sel(rd_sel),
		.reg_wr_val(reg_wr_val),
		.update_rd_out(update_rd_out),
		.rd_sel_out(rd_sel_out),
		.complete(complete),
		.fault(fault),
		.dbg_en(dbg_en),
		.dbg_access(dbg_access),
		.dbg_wr_en(dbg_wr_en),
		.dbg_addr(dbg_addr),
		.dbg_width(dbg_width),
		.dbg_wr_val(dbg_wr_val),
		.dbg_rd_val(dbg_rd_val),
		.dbg_compl(dbg_compl),
		.bus(bus.master)
	);

	data_ram u_data_ram (
		.clk(clk),
		.rst(rst),
		.bus(bus.slave)
	);

endmodule

//--- dv/mem_subsys_tb.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_subsys_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_TESTS = 5;
	// accesses one test may spend, and cycles per access including the gap.
	localparam int ACCESS_BUDGET = 80;
	localparam int ACCESS_CYCLES = 4;
	localparam int ACK_LIMIT = 16;
	localparam int IDX_WIDTH = $clog2(`RAM_WORDS);

	logic clk;
	logic rst;
	logic load;
	logic store;
	logic [`DATA_WIDTH-1:0] addr;
	logic [`DATA_WIDTH-1:0] mdr;
	logic mem_wr_en;
	cpu_pkg::mem_width_t width;
	logic [`DATA_WIDTH-1:0] wr_val;
	logic update_rd;
	cpu_pkg::reg_sel_t rd_sel;
	logic [`DATA_WIDTH-1:0] reg_wr_val;
	logic update_rd_out;
	cpu_pkg::reg_sel_t rd_sel_out;
	logic complete;
	logic fault;
	logic dbg_en;
	logic dbg_access;
	logic dbg_wr_en;
	logic [`DATA_WIDTH-1:0] dbg_addr;
	cpu_pkg::mem_width_t dbg_width;
	logic [`DATA_WIDTH-1:0] dbg_wr_val;
	logic [`DATA_WIDTH-1:0] dbg_rd_val;
	logic dbg_compl;

	// reference copy of the RAM contents.
	logic [`DATA_WIDTH-1:0] model [`RAM_WORDS];
	logic [31:0] lfsr_state;
	string cur_test;

	// outputs captured in the cycle where complete is high.
	logic [`DATA_WIDTH-1:0] res_val;
	logic [`DATA_WIDTH-1:0] res_dbg_val;
	logic res_upd;
	logic res_fault;
	logic res_dbg_compl;
	cpu_pkg::reg_sel_t res_sel;

	mem_subsys_top uut (
		.clk(clk),
		.rst(rst),
		.load(load),
		.store(store),
		.addr(addr),
		.mdr(mdr),
		.mem_wr_en(mem_wr_en),
		.width(width),
		.wr_val(wr_val),
		.update_rd(update_rd),
		.rd_sel(rd_sel),
		.reg_wr_val(reg_wr_val),
		.update_rd_out(update_rd_out),
		.rd_sel_out(rd_sel_out),
		.complete(complete),
		.fault(fault),
		.dbg_en(dbg_en),
		.dbg_access(dbg_access),
		.dbg_wr_en(dbg_wr_en),
		.dbg_addr(dbg_addr),
		.dbg_width(dbg_width),
		.dbg_wr_val(dbg_wr_val),
		.dbg_rd_val(dbg_rd_val),
		.dbg_compl(dbg_compl)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((RESET_CYCLES + NUM_TESTS * ACCESS_BUDGET * ACCESS_CYCLES) * CLK_PERIOD);
		report_failure("watchdog expired before the tests finished");
	end

	// ==================================================
	// helpers.
	// ==================================================

	task automatic report_failure(input string reason);
		$display("Error: %s", reason);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_equal(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else
			report_failure($sformatf("%s, %s expected %h actual %h",
				cur_test, what, expected, actual));
	endtask

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] word_addr(input logic [29:0] idx, input logic [1:0] off);
		return {idx, off};
	endfunction

	// store data arrives in the low bits and lands in the lane picked by the offset.
	function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] val,
			input cpu_pkg::mem_width_t w, input logic [1:0] off);
		logic [31:0] r;
		r = old;
		case (w)
		cpu_pkg::width_byte: r[off*8 +: 8] = val[7:0];
		cpu_pkg::width_half: r[off[1]*16 +: 16] = val[15:0];
		default: r = val;
		endcase
		return r;
	endfunction

	function automatic logic [31:0] lane_value(input logic [31:0] word,
			input cpu_pkg::mem_width_t w, input logic [1:0] off);
		logic [31:0] r;
		case (w)
		cpu_pkg::width_byte: r = {24'h0, word[off*8 +: 8]};
		cpu_pkg::width_half: r = {16'h0, word[off[1]*16 +: 16]};
		default: r = word;
		endcase
		return r;
	endfunction

	// called on a falling edge, returns on a falling edge.
	task automatic bus_access(input logic use_dbg, input logic is_write, input logic [31:0] a,
			input logic [31:0] data, input cpu_pkg::mem_width_t w, input cpu_pkg::reg_sel_t rs);
		int cycles;
		if (use_dbg) begin
			dbg_en = 1'b1;
			dbg_access = 1'b1;
			dbg_wr_en = is_write;
			dbg_addr = a;
			dbg_width = w;
			dbg_wr_val = data;
		end else begin
			load = !is_write;
			store = is_write;
			mem_wr_en = is_write;
			addr = a;
			mdr = data;
			width = w;
			rd_sel = rs;
			update_rd = is_write;
		end
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!complete && cycles < ACK_LIMIT);
		assert (complete) else report_failure("complete never rose for a bus access");
		check_equal("complete latency", 2, cycles);
		res_val = reg_wr_val;
		res_dbg_val = dbg_rd_val;
		res_upd = update_rd_out;
		res_fault = fault;
		res_dbg_compl = dbg_compl;
		res_sel = rd_sel_out;
		// the request stays up over the edge where the ack is sampled.
		@(negedge clk);
		load = 1'b0;
		store = 1'b0;
		mem_wr_en = 1'b0;
		update_rd = 1'b0;
		dbg_en = 1'b0;
		dbg_access = 1'b0;
		dbg_wr_en = 1'b0;
	endtask

	task automatic pipe_store(input logic [31:0] a, input logic [31:0] data,
			input cpu_pkg::mem_width_t w);
		bus_access(1'b0, 1'b1, a, data, w, '0);
		model[a[IDX_WIDTH+1:2]] = merge_store(model[a[IDX_WIDTH+1:2]], data, w, a[1:0]);
		check_equal("store update_rd_out", 0, res_upd);
		check_equal("store fault", 0, res_fault);
	endtask

	task automatic pipe_load(input logic [31:0] a, input cpu_pkg::mem_width_t w);
		cpu_pkg::reg_sel_t rs;
		rs = cpu_pkg::reg_sel_t'(rand_bits(`REG_SEL_WIDTH));
		bus_access(1'b0, 1'b0, a, '0, w, rs);
		check_equal("load data", lane_value(model[a[IDX_WIDTH+1:2]], w, a[1:0]), res_val);
		check_equal("load update_rd_out", 1, res_upd);
		check_equal("load rd_sel_out", rs, res_sel);
		check_equal("load fault", 0, res_fault);
	endtask

	// ==================================================
	// tests.
	// ==================================================

	task automatic test_word_round_trip();
		logic [IDX_WIDTH-1:0] idx [16];
		cur_test = "word round trip";
		for (int i = 0; i < 16; i++) begin
			idx[i] = rand_bits(IDX_WIDTH);
			pipe_store(word_addr(idx[i], 2'b00), rand_bits(32), cpu_pkg::width_word);
		end
		for (int i = 0; i < 16; i++)
			pipe_load(word_addr(idx[i], 2'b00), cpu_pkg::width_word);
	endtask

	task automatic test_lanes();
		logic [IDX_WIDTH-1:0] idx;
		cur_test = "byte and half lanes";
		for (int n = 0; n < 4; n++) begin
			idx = rand_bits(IDX_WIDTH);
			pipe_store(word_addr(idx, 2'b00), rand_bits(32), cpu_pkg::width_word);
			for (int off = 0; off < 4; off++)
				pipe_store(word_addr(idx, off), rand_bits(8), cpu_pkg::width_byte);
			for (int off = 0; off < 4; off += 2)
				pipe_store(word_addr(idx, off), rand_bits(16), cpu_pkg::width_half);
			for (int off = 0; off < 4; off++)
				pipe_load(word_addr(idx, off), cpu_pkg::width_byte);
			for (int off = 0; off < 4; off++)
				pipe_load(word_addr(idx, off), cpu_pkg::width_half);
			pipe_load(word_addr(idx, 2'b00), cpu_pkg::width_word);
		end
	endtask

	task automatic test_bypass();
		logic [31:0] v;
		logic u;
		cpu_pkg::reg_sel_t s;
		cur_test = "bypass";
		for (int n = 0; n < 16; n++) begin
			v = rand_bits(32);
			u = 1'(rand_bits(1));
			s = cpu_pkg::reg_sel_t'(rand_bits(`REG_SEL_WIDTH));
			wr_val = v;
			update_rd = u;
			rd_sel = s;
			@(negedge clk);
			check_equal("reg_wr_val", v, reg_wr_val);
			check_equal("update_rd_out", u, update_rd_out);
			check_equal("rd_sel_out", s, rd_sel_out);
			check_equal("complete", 0, complete);
		end
		wr_val = '0;
		update_rd = 1'b0;
		rd_sel = '0;
	endtask

	task automatic test_debug();
		logic [IDX_WIDTH-1:0] idx;
		logic [31:0] a;
		logic [31:0] data;
		cpu_pkg::mem_width_t w;
		cur_test = "debug access";
		for (int n = 0; n < 12; n++) begin
			idx = rand_bits(IDX_WIDTH);
			w = cpu_pkg::width_word;
			a = word_addr(idx, 2'b00);
			data = rand_bits(32);
			bus_access(1'b1, 1'b1, a, data, w, '0);
			model[idx] = merge_store(model[idx], data, w, a[1:0]);
			for (int k = 0; k < 3; k++) begin
				w = cpu_pkg::mem_width_t'(k);
				a = word_addr(idx, 2'(rand_bits(2)));
				data = rand_bits(32);
				if (n % 2 == 0) begin
					bus_access(1'b1, 1'b1, a, data, w, '0);
					model[idx] = merge_store(model[idx], data, w, a[1:0]);
				end
				bus_access(1'b1, 1'b0, a, '0, w, '0);
				check_equal("dbg_rd_val", lane_value(model[idx], w, a[1:0]), res_dbg_val);
				check_equal("dbg_compl", 1, res_dbg_compl);
				check_equal("update_rd_out", 0, res_upd);
			end
		end
	endtask

	task automatic test_bus_error();
		logic [IDX_WIDTH-1:0] k;
		logic [29:0] err_idx;
		cur_test = "bus error";
		for (int n = 0; n < 4; n++) begin
			k = rand_bits(IDX_WIDTH);
			pipe_store(word_addr(k, 2'b00), rand_bits(32), cpu_pkg::width_word);
			err_idx = 30'(k) + 30'(`RAM_WORDS) * (30'(rand_bits(4)) + 30'd1);
			bus_access(1'b0, 1'b0, word_addr(err_idx, 2'b00), '0, cpu_pkg::width_word, 3'd5);
			check_equal("load fault", 1, res_fault);
			check_equal("load data", 0, res_val);
			check_equal("load update_rd_out", 0, res_upd);
			bus_access(1'b0, 1'b1, word_addr(err_idx, 2'b00), rand_bits(32),
				cpu_pkg::width_word, '0);
			check_equal("store fault", 1, res_fault);
			check_equal("store update_rd_out", 0, res_upd);
			// the aliased in-range word must be untouched.
			pipe_load(word_addr(k, 2'b00), cpu_pkg::width_word);
		end
	endtask

	// ==================================================
	// sequence.
	// ==================================================

	initial begin
		lfsr_state = 32'h3805;
		rst = 1'b1;
		load = 1'b0;
		store = 1'b0;
		addr = '0;
		mdr = '0;
		mem_wr_en = 1'b0;
		width = cpu_pkg::width_word;
		// nonzero writeback inputs, reset alone keeps the bypass registers clear.
		wr_val = '1;
		update_rd = 1'b1;
		rd_sel = '1;
		dbg_en = 1'b0;
		dbg_access = 1'b0;
		dbg_wr_en = 1'b0;
		dbg_addr = '0;
		dbg_width = cpu_pkg::width_word;
		dbg_wr_val = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		cur_test = "reset";
		check_equal("complete", 0, complete);
		check_equal("fault", 0, fault);
		check_equal("update_rd_out", 0, update_rd_out);
		check_equal("dbg_compl", 0, dbg_compl);
		check_equal("reg_wr_val", 0, reg_wr_val);
		check_equal("rd_sel_out", 0, rd_sel_out);
		rst = 1'b0;
		wr_val = '0;
		update_rd = 1'b0;
		rd_sel = '0;
		test_word_round_trip();
		test_lanes();
		test_bypass();
		test_debug();
		test_bus_error();
		$display("** PASS **");
		$finish;
	end

endmodule

//--- src.f
+incdir+source
source/cpu_pkg.sv
source/bus_pkg.sv
source/data_bus_if.sv
source/mem_stage.sv
source/data_ram.sv
source/mem_subsys_top.sv
dv/mem_subsys_tb.sv
